// ==== tlb_pkg.sv ====
// TLB shared definitions
package tlb_pkg;

  // ----------------------------------------------------------------------
  // Sizes
  // ----------------------------------------------------------------------
  localparam int TLB_ORDER      = 4;
  localparam int N_ASSOC        = 4;
  localparam int WAY_BITS       = 2;
  localparam int PG_BITS        = 12;
  localparam int VADDR_BITS     = 32;
  localparam int PADDR_BITS     = 32;
  localparam int TAG_BITS       = VADDR_BITS - TLB_ORDER - PG_BITS;
  localparam int PHY_BITS       = PADDR_BITS - PG_BITS;
  localparam int PID_BITS       = 6;
  localparam int HPID_BITS      = 8;
  localparam int REF_CLR_PERIOD = 4096;
  localparam int LUP_LATENCY    = 3;
  // Mapping command word
  localparam int CMD_BITS       = 64;

  // ----------------------------------------------------------------------
  // Table entry and command word
  // ----------------------------------------------------------------------
  typedef struct packed {
    logic [TAG_BITS-1:0]  tag;
    logic [PID_BITS-1:0]  pid;
    logic                 valid;
    logic [PHY_BITS-1:0]  ppn;
    logic [HPID_BITS-1:0] hpid;
  } tlb_entry_t;

  // Insert decode, full entry
  typedef struct packed {
    logic                                         op_insert;
    logic [CMD_BITS-2-TLB_ORDER-$bits(tlb_entry_t):0] pad;
    logic [TLB_ORDER-1:0]                         set_idx;
    tlb_entry_t                                   entry;
  } tlb_cmd_ins_t;

  // Remove decode, match key only
  typedef struct packed {
    logic                                            op_insert;
    logic [CMD_BITS-2-TLB_ORDER-TAG_BITS-HPID_BITS:0] pad;
    logic [TLB_ORDER-1:0]                            set_idx;
    logic [TAG_BITS-1:0]                             tag;
    logic [HPID_BITS-1:0]                            hpid;
  } tlb_cmd_rmv_t;

  // Top bit selects the view
  typedef union packed {
    tlb_cmd_ins_t ins;
    tlb_cmd_rmv_t rmv;
  } tlb_cmd_u;

  // ----------------------------------------------------------------------
  // Lookup port and reference pair
  // ----------------------------------------------------------------------
  typedef struct packed {
    logic                  valid;
    logic                  wr;
    logic [PID_BITS-1:0]   pid;
    logic [VADDR_BITS-1:0] vaddr;
  } tlb_lup_req_t;

  typedef struct packed {
    logic                 valid;
    logic                 hit;
    logic [PHY_BITS-1:0]  ppn;
    logic [HPID_BITS-1:0] hpid;
  } tlb_lup_rsp_t;

  // Referenced is the upper bit when compared
  typedef struct packed {
    logic referenced;
    logic modified;
  } tlb_ref_t;

endpackage

// ==== tlb_ram.sv ====
// TLB entry storage

`timescale 1ns/1ps

module tlb_ram (
  input  logic                                      aclk,
  input  logic [tlb_pkg::N_ASSOC-1:0]               a_we,
  input  logic [tlb_pkg::TLB_ORDER-1:0]             a_addr,
  input  tlb_pkg::tlb_entry_t                       a_wdata,
  input  logic [tlb_pkg::TLB_ORDER-1:0]             b_addr,
  output tlb_pkg::tlb_entry_t [tlb_pkg::N_ASSOC-1:0] a_rdata,
  output tlb_pkg::tlb_entry_t [tlb_pkg::N_ASSOC-1:0] b_rdata
);
  import tlb_pkg::*;

  // One array per way, cleared at configuration
  tlb_entry_t           mem [N_ASSOC][2**TLB_ORDER] = '{default: '0};
  logic [TLB_ORDER-1:0] a_addr_q;
  logic [TLB_ORDER-1:0] b_addr_q;

  // Registered address, registered data, two cycles per read
  always_ff @(posedge aclk) begin
    a_addr_q <= a_addr;
    b_addr_q <= b_addr;
    for (int w = 0; w < N_ASSOC; w++) begin
      // Update port write
      if (a_we[w]) begin
        mem[w][a_addr] <= a_wdata;
      end
      a_rdata[w] <= mem[w][a_addr_q];
      b_rdata[w] <= mem[w][b_addr_q];
    end
  end

endmodule

// ==== tlb_ref_bits.sv ====
// TLB reference bit arrays

`timescale 1ns/1ps

module tlb_ref_bits (
  input  logic                                    aclk,
  input  logic                                    aresetn,
  input  logic                                    hit_valid,
  input  logic                                    hit_wr,
  input  logic [tlb_pkg::TLB_ORDER-1:0]           hit_set,
  input  logic [tlb_pkg::WAY_BITS-1:0]            hit_way,
  input  logic [tlb_pkg::N_ASSOC-1:0]             clr_we,
  input  logic [tlb_pkg::TLB_ORDER-1:0]           clr_set,
  input  logic [tlb_pkg::TLB_ORDER-1:0]           rd_set,
  output tlb_pkg::tlb_ref_t [tlb_pkg::N_ASSOC-1:0] rd_ref
);
  import tlb_pkg::*;

  localparam int TMR_BITS = $clog2(REF_CLR_PERIOD);

  logic [N_ASSOC-1:0]   ref_r [2**TLB_ORDER];
  logic [N_ASSOC-1:0]   ref_m [2**TLB_ORDER];
  logic [TLB_ORDER-1:0] rd_set_q;
  logic [TMR_BITS-1:0]  tmr_q;
  logic                 init_act;
  logic                 sweep_act;
  logic [TLB_ORDER-1:0] sweep_set;

  // ----------------------------------------------------------------------
  // Sweep timer
  // ----------------------------------------------------------------------
  // Reset starts a full clear, then the periodic count
  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      tmr_q     <= '0;
      init_act  <= 1'b1;
      sweep_act <= 1'b0;
      sweep_set <= '0;
    end else if (init_act || sweep_act) begin
      // One set per cycle
      sweep_set <= sweep_set + 1'b1;
      if (&sweep_set) begin
        init_act  <= 1'b0;
        sweep_act <= 1'b0;
      end
    end else if (tmr_q == TMR_BITS'(REF_CLR_PERIOD - 1)) begin
      tmr_q     <= '0;
      sweep_act <= 1'b1;
    end else begin
      tmr_q <= tmr_q + 1'b1;
    end
  end

  // ----------------------------------------------------------------------
  // Bit updates
  // ----------------------------------------------------------------------
  always_ff @(posedge aclk) begin
    // Sweep first, a hit on the same set overrides it
    if (init_act || sweep_act) begin
      ref_r[sweep_set] <= '0;
    end
    // Modified bits only cleared by the reset sweep
    if (init_act) begin
      ref_m[sweep_set] <= '0;
    end
    if (hit_valid) begin
      ref_r[hit_set][hit_way] <= 1'b1;
      if (hit_wr) begin
        ref_m[hit_set][hit_way] <= 1'b1;
      end
    end
    // Insert or remove restarts the pair
    for (int w = 0; w < N_ASSOC; w++) begin
      if (clr_we[w]) begin
        ref_r[clr_set][w] <= 1'b0;
        ref_m[clr_set][w] <= 1'b0;
      end
    end
  end

  // Read, same latency as RAM port A
  always_ff @(posedge aclk) begin
    rd_set_q <= rd_set;
    for (int w = 0; w < N_ASSOC; w++) begin
      rd_ref[w].referenced <= ref_r[rd_set_q][w];
      rd_ref[w].modified   <= ref_m[rd_set_q][w];
    end
  end

endmodule

// ==== tlb_victim_select.sv ====
// TLB insert way selection

`timescale 1ns/1ps

module tlb_victim_select (
  input  tlb_pkg::tlb_entry_t [tlb_pkg::N_ASSOC-1:0] ways,
  input  tlb_pkg::tlb_ref_t [tlb_pkg::N_ASSOC-1:0]   refs,
  output logic [tlb_pkg::WAY_BITS-1:0]              victim
);
  import tlb_pkg::*;

  logic                free;
  logic [WAY_BITS-1:0] free_way;
  logic [WAY_BITS-1:0] lru_way;
  tlb_ref_t            min_ref;

  always_comb begin
    free     = 1'b0;
    free_way = '0;
    lru_way  = '0;
    min_ref  = 2'b11;

    // Downward scan, lowest empty way is kept
    for (int w = N_ASSOC - 1; w >= 0; w--) begin
      if (!ways[w].valid) begin
        free     = 1'b1;
        free_way = WAY_BITS'(w);
      end
    end

    // Upward scan, ties go to the higher way
    for (int w = 0; w < N_ASSOC; w++) begin
      if (refs[w] <= min_ref) begin
        lru_way = WAY_BITS'(w);
        min_ref = refs[w];
      end
    end

    victim = free ? free_way : lru_way;
  end

endmodule

// ==== tlb_lookup.sv ====
// TLB lookup pipeline

`timescale 1ns/1ps

module tlb_lookup (
  input  logic                                      aclk,
  input  logic                                      aresetn,
  input  tlb_pkg::tlb_lup_req_t                     lup_req,
  input  tlb_pkg::tlb_entry_t [tlb_pkg::N_ASSOC-1:0] b_rdata,
  output logic [tlb_pkg::TLB_ORDER-1:0]             b_addr,
  output tlb_pkg::tlb_lup_rsp_t                     lup_rsp,
  output logic                                      hit_valid,
  output logic                                      hit_wr,
  output logic [tlb_pkg::TLB_ORDER-1:0]             hit_set,
  output logic [tlb_pkg::WAY_BITS-1:0]              hit_way
);
  import tlb_pkg::*;

  // Request delay up to the RAM data, last cycle is the result register
  localparam int N_STG = LUP_LATENCY - 1;

  tlb_lup_req_t        req_q [N_STG];
  tlb_lup_req_t        req_c;
  logic [TAG_BITS-1:0] tag_c;
  logic [N_ASSOC-1:0]  match;
  logic                hit_any;

  // Set index straight to RAM port B
  assign b_addr = lup_req.vaddr[PG_BITS +: TLB_ORDER];

  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      for (int s = 0; s < N_STG; s++) begin
        req_q[s] <= '0;
      end
    end else begin
      req_q[0] <= lup_req;
      for (int s = 1; s < N_STG; s++) begin
        req_q[s] <= req_q[s-1];
      end
    end
  end

  // ----------------------------------------------------------------------
  // Compare stage
  // ----------------------------------------------------------------------
  assign req_c = req_q[N_STG-1];
  assign tag_c = req_c.vaddr[PG_BITS+TLB_ORDER +: TAG_BITS];

  // Highest matching way wins
  always_comb begin
    hit_any = 1'b0;
    hit_way = '0;
    for (int w = 0; w < N_ASSOC; w++) begin
      match[w] = b_rdata[w].valid && (b_rdata[w].tag == tag_c) &&
                 (b_rdata[w].pid == req_c.pid);
      if (match[w]) begin
        hit_any = 1'b1;
        hit_way = WAY_BITS'(w);
      end
    end
  end

  // Reference update for the hit way
  assign hit_valid = req_c.valid && hit_any;
  assign hit_wr    = req_c.wr;
  assign hit_set   = req_c.vaddr[PG_BITS +: TLB_ORDER];

  // Result register, zero payload on a miss
  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      lup_rsp <= '0;
    end else begin
      lup_rsp.valid <= req_c.valid;
      lup_rsp.hit   <= hit_valid;
      lup_rsp.ppn   <= hit_valid ? b_rdata[hit_way].ppn : '0;
      lup_rsp.hpid  <= hit_valid ? b_rdata[hit_way].hpid : '0;
    end
  end

endmodule

// ==== tlb_controller.sv ====
// TLB command state machine

`timescale 1ns/1ps

module tlb_controller (
  input  logic                                      aclk,
  input  logic                                      aresetn,
  input  tlb_pkg::tlb_cmd_u                         cmd,
  input  logic                                      cmd_valid,
  output logic                                      cmd_ready,
  input  tlb_pkg::tlb_entry_t [tlb_pkg::N_ASSOC-1:0] a_rdata,
  input  logic [tlb_pkg::WAY_BITS-1:0]              victim,
  output logic [tlb_pkg::N_ASSOC-1:0]               a_we,
  output logic [tlb_pkg::TLB_ORDER-1:0]             a_addr,
  output tlb_pkg::tlb_entry_t                       a_wdata,
  output logic [tlb_pkg::N_ASSOC-1:0]               clr_we,
  output logic [tlb_pkg::TLB_ORDER-1:0]             clr_set
);
  import tlb_pkg::*;

  typedef enum logic [1:0] {ST_IDLE, ST_WAIT_1, ST_WAIT_2, ST_COMP} state_t;

  state_t     state_q;
  state_t     state_d;
  tlb_cmd_u   cmd_q;
  logic       is_insert;
  tlb_entry_t ins_entry;

  // ----------------------------------------------------------------------
  // State and command registers
  // ----------------------------------------------------------------------
  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      state_q <= ST_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // Held for the whole read-modify-write
  always_ff @(posedge aclk) begin
    if (cmd_valid && cmd_ready) begin
      cmd_q <= cmd;
    end
  end

  // Accept, two read cycles, then write
  always_comb begin
    state_d = state_q;
    case (state_q)
      ST_IDLE: begin
        if (cmd_valid) begin
          state_d = ST_WAIT_1;
        end
      end
      ST_WAIT_1: begin
        state_d = ST_WAIT_2;
      end
      ST_WAIT_2: begin
        state_d = ST_COMP;
      end
      default: begin
        state_d = ST_IDLE;
      end
    endcase
  end

  assign cmd_ready = (state_q == ST_IDLE);

  // ----------------------------------------------------------------------
  // Command decode
  // ----------------------------------------------------------------------
  assign is_insert = cmd_q.ins.op_insert;
  // Set index sits at a different offset in each view
  assign a_addr    = is_insert ? cmd_q.ins.set_idx : cmd_q.rmv.set_idx;
  assign clr_set   = a_addr;

  // Inserted entries always valid
  always_comb begin
    ins_entry       = cmd_q.ins.entry;
    ins_entry.valid = 1'b1;
  end

  // Remove writes an all-zero entry
  assign a_wdata = is_insert ? ins_entry : tlb_entry_t'('0);

  always_comb begin
    a_we = '0;
    if (state_q == ST_COMP) begin
      if (is_insert) begin
        a_we[victim] = 1'b1;
      end else begin
        // Every way with matching tag and host pid
        for (int w = 0; w < N_ASSOC; w++) begin
          if ((a_rdata[w].tag == cmd_q.rmv.tag) &&
              (a_rdata[w].hpid == cmd_q.rmv.hpid)) begin
            a_we[w] = 1'b1;
          end
        end
      end
    end
  end

  // Reference pair cleared for each written way
  assign clr_we = a_we;

endmodule

// ==== tlb_top.sv ====
// TLB top level

`timescale 1ns/1ps

module tlb_top (
  input  logic                  aclk,
  input  logic                  aresetn,
  input  tlb_pkg::tlb_cmd_u     cmd,
  input  logic                  cmd_valid,
  output logic                  cmd_ready,
  input  tlb_pkg::tlb_lup_req_t lup_req,
  output tlb_pkg::tlb_lup_rsp_t lup_rsp
);
  import tlb_pkg::*;

  // Update side
  logic [N_ASSOC-1:0]               a_we;
  logic [TLB_ORDER-1:0]             a_addr;
  tlb_entry_t                       a_wdata;
  tlb_entry_t [N_ASSOC-1:0]         a_rdata;
  logic [WAY_BITS-1:0]              victim;
  tlb_ref_t [N_ASSOC-1:0]           rd_ref;
  logic [N_ASSOC-1:0]               clr_we;
  logic [TLB_ORDER-1:0]             clr_set;
  // Lookup side
  logic [TLB_ORDER-1:0]             b_addr;
  tlb_entry_t [N_ASSOC-1:0]         b_rdata;
  logic                             hit_valid;
  logic                             hit_wr;
  logic [TLB_ORDER-1:0]             hit_set;
  logic [WAY_BITS-1:0]              hit_way;

  tlb_controller u_ctrl (
    .aclk     (aclk),
    .aresetn  (aresetn),
    .cmd      (cmd),
    .cmd_valid(cmd_valid),
    .cmd_ready(cmd_ready),
    .a_rdata  (a_rdata),
    .victim   (victim),
    .a_we     (a_we),
    .a_addr   (a_addr),
    .a_wdata  (a_wdata),
    .clr_we   (clr_we),
    .clr_set  (clr_set)
  );

  tlb_ram u_ram (
    .aclk   (aclk),
    .a_we   (a_we),
    .a_addr (a_addr),
    .a_wdata(a_wdata),
    .b_addr (b_addr),
    .a_rdata(a_rdata),
    .b_rdata(b_rdata)
  );

  // Reference pairs read alongside port A
  tlb_ref_bits u_ref (
    .aclk     (aclk),
    .aresetn  (aresetn),
    .hit_valid(hit_valid),
    .hit_wr   (hit_wr),
    .hit_set  (hit_set),
    .hit_way  (hit_way),
    .clr_we   (clr_we),
    .clr_set  (clr_set),
    .rd_set   (a_addr),
    .rd_ref   (rd_ref)
  );

  tlb_victim_select u_victim (
    .ways  (a_rdata),
    .refs  (rd_ref),
    .victim(victim)
  );

  tlb_lookup u_lookup (
    .aclk     (aclk),
    .aresetn  (aresetn),
    .lup_req  (lup_req),
    .b_rdata  (b_rdata),
    .b_addr   (b_addr),
    .lup_rsp  (lup_rsp),
    .hit_valid(hit_valid),
    .hit_wr   (hit_wr),
    .hit_set  (hit_set),
    .hit_way  (hit_way)
  );

endmodule

// ==== tlb_properties.sv ====
// TLB bound assertions

`timescale 1ns/1ps

module tlb_properties (
  input logic                  aclk,
  input logic                  aresetn,
  input logic                  cmd_valid,
  input logic                  cmd_ready,
  input tlb_pkg::tlb_lup_req_t lup_req,
  input tlb_pkg::tlb_lup_rsp_t lup_rsp
);

  // Count of failed assertions for the end of the run
  int fail_cnt = 0;

  // Busy through WAIT_1, WAIT_2 and COMP
  a_cmd_busy: assert property (@(posedge aclk) disable iff (!aresetn)
    (cmd_valid && cmd_ready) |=> !cmd_ready [*3])
    else begin
      $error("cmd_ready high within three cycles of an accepted command");
      fail_cnt++;
    end

  // Every request gets its response three cycles later
  a_lup_latency: assert property (@(posedge aclk) disable iff (!aresetn)
    lup_req.valid |-> ##3 lup_rsp.valid)
    else begin
      $error("lookup response valid not three cycles after the request");
      fail_cnt++;
    end

  // No response without a request three cycles before
  a_lup_no_extra: assert property (@(posedge aclk) disable iff (!aresetn)
    lup_rsp.valid |-> $past(lup_req.valid, 3))
    else begin
      $error("lookup response valid without a request three cycles before");
      fail_cnt++;
    end

  // Hit only qualifies a valid response
  a_hit_valid: assert property (@(posedge aclk) disable iff (!aresetn)
    lup_rsp.hit |-> lup_rsp.valid)
    else begin
      $error("lookup hit without response valid");
      fail_cnt++;
    end

endmodule

bind tlb_top tlb_properties u_props (
  .aclk     (aclk),
  .aresetn  (aresetn),
  .cmd_valid(cmd_valid),
  .cmd_ready(cmd_ready),
  .lup_req  (lup_req),
  .lup_rsp  (lup_rsp)
);

// ==== tb_tlb_top.sv ====
// TLB testbench

`timescale 1ns/1ps

module tb_tlb_top;
  import tlb_pkg::*;

  typedef enum int {OP_CMD, OP_LUP, OP_PIPE} op_e;

  localparam int N_ENT = 12;

  logic         aclk = 1'b0;
  logic         aresetn;
  tlb_cmd_u     cmd;
  logic         cmd_valid;
  logic         cmd_ready;
  tlb_lup_req_t lup_req;
  tlb_lup_rsp_t lup_rsp;

  // Stimulus table with one entry per row
  op_e          row_op[$];
  string        row_name[$];
  tlb_cmd_u     row_cmd[$];
  tlb_lup_req_t row_req[$];
  tlb_lup_rsp_t row_exp[$];

  // Lookups in flight and the cycle each response is due
  tlb_lup_rsp_t exp_q[$];
  int           due_q[$];
  string        name_q[$];

  // Mappings used by the table
  logic [TAG_BITS-1:0]  e_tag  [N_ENT];
  logic [TLB_ORDER-1:0] e_set  [N_ENT];
  logic [PID_BITS-1:0]  e_pid  [N_ENT];
  logic [PHY_BITS-1:0]  e_ppn  [N_ENT];
  logic [HPID_BITS-1:0] e_hpid [N_ENT];

  int          cyc = 0;
  int          cyc_limit = 0;
  logic [31:0] lcg_state = 32'd92426;

  tlb_top u_dut (
    .aclk     (aclk),
    .aresetn  (aresetn),
    .cmd      (cmd),
    .cmd_valid(cmd_valid),
    .cmd_ready(cmd_ready),
    .lup_req  (lup_req),
    .lup_rsp  (lup_rsp)
  );

  always #5 aclk = ~aclk;

  // ----------------------------------------------------------------------
  // Cycle count and run limit
  // ----------------------------------------------------------------------
  always @(posedge aclk) begin
    cyc <= cyc + 1;
    if (cyc_limit > 0 && cyc >= cyc_limit) begin
      $display("Timeout: the tests did not finish within %0d cycles", cyc_limit);
      $display("tests failed");
      $fatal(1, "Run stopped by the cycle limit");
    end
  end

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state;
  endfunction

  // Tag and set index followed by an arbitrary page offset
  function automatic logic [VADDR_BITS-1:0] make_vaddr(input logic [TAG_BITS-1:0] tag,
                                                       input logic [TLB_ORDER-1:0] set);
    return {tag, set, 12'h3c8};
  endfunction

  // ----------------------------------------------------------------------
  // Table building
  // ----------------------------------------------------------------------
  function automatic void push_row(input op_e op, input string name, input tlb_cmd_u c,
                                   input tlb_lup_req_t q, input tlb_lup_rsp_t e);
    row_op.push_back(op);
    row_name.push_back(name);
    row_cmd.push_back(c);
    row_req.push_back(q);
    row_exp.push_back(e);
  endfunction

  function automatic void set_ent(input int k, input logic [TLB_ORDER-1:0] set,
                                  input logic [TAG_BITS-1:0] tag,
                                  input logic [PID_BITS-1:0] pid);
    e_set[k] = set;
    e_tag[k] = tag;
    e_pid[k] = pid;
  endfunction

  function automatic void add_ins(input string name, input int k);
    tlb_cmd_u c;
    c                     = '0;
    c.ins.op_insert       = 1'b1;
    c.ins.set_idx         = e_set[k];
    c.ins.entry.tag       = e_tag[k];
    c.ins.entry.pid       = e_pid[k];
    c.ins.entry.valid     = 1'b1;
    c.ins.entry.ppn       = e_ppn[k];
    c.ins.entry.hpid      = e_hpid[k];
    push_row(OP_CMD, name, c, '0, '0);
  endfunction

  // Remove keys on tag and host pid only
  function automatic void add_rmv(input string name, input int k);
    tlb_cmd_u c;
    c               = '0;
    c.rmv.op_insert = 1'b0;
    c.rmv.set_idx   = e_set[k];
    c.rmv.tag       = e_tag[k];
    c.rmv.hpid      = e_hpid[k];
    push_row(OP_CMD, name, c, '0, '0);
  endfunction

  // Lookup of mapping k that is expected to hit
  function automatic void add_hit(input op_e op, input string name, input int k,
                                  input logic wr);
    tlb_lup_req_t q;
    tlb_lup_rsp_t e;
    q.valid = 1'b1;
    q.wr    = wr;
    q.pid   = e_pid[k];
    q.vaddr = make_vaddr(e_tag[k], e_set[k]);
    e.valid = 1'b1;
    e.hit   = 1'b1;
    e.ppn   = e_ppn[k];
    e.hpid  = e_hpid[k];
    push_row(op, name, '0, q, e);
  endfunction

  // A miss returns valid with an all-zero payload
  function automatic void add_miss(input op_e op, input string name,
                                   input logic [TLB_ORDER-1:0] set,
                                   input logic [TAG_BITS-1:0] tag,
                                   input logic [PID_BITS-1:0] pid);
    tlb_lup_req_t q;
    tlb_lup_rsp_t e;
    q.valid = 1'b1;
    q.wr    = 1'b0;
    q.pid   = pid;
    q.vaddr = make_vaddr(tag, set);
    e       = '0;
    e.valid = 1'b1;
    push_row(op, name, '0, q, e);
  endfunction

  task automatic build_table();
    logic [31:0] r;
    for (int k = 0; k < N_ENT; k++) begin
      r         = lcg_next();
      e_ppn[k]  = r[31 -: PHY_BITS];
      e_hpid[k] = r[11 -: HPID_BITS];
    end
    set_ent(0, 4'd3, 16'h1234, 6'd5);
    set_ent(1, 4'd3, 16'h0777, 6'd9);
    // Ways 0 to 3 of set 5 and then the overflow insert
    for (int k = 2; k <= 6; k++) begin
      set_ent(k, 4'd5, TAG_BITS'(16'h0500 + k), 6'd2);
    end
    // Ways 0 to 3 of set 9 and then the replacing insert
    for (int k = 7; k <= 11; k++) begin
      set_ent(k, 4'd9, TAG_BITS'(16'h0900 + k), 6'd3);
    end

    // Empty table
    add_miss(OP_LUP, "reset_miss", 4'd7, 16'hbeef, 6'd1);
    // Insert and lookup followed by pid and tag misses
    add_ins("ins_a", 0);
    add_hit(OP_LUP, "hit_a", 0, 1'b0);
    add_miss(OP_LUP, "miss_pid", 4'd3, 16'h1234, 6'd6);
    add_miss(OP_LUP, "miss_tag", 4'd3, 16'h1235, 6'd5);
    add_ins("ins_b", 1);
    add_hit(OP_LUP, "hit_b", 1, 1'b0);
    // Remove leaves the neighbour in place
    add_rmv("rmv_a", 0);
    add_miss(OP_LUP, "miss_a", 4'd3, 16'h1234, 6'd5);
    add_hit(OP_LUP, "hit_b_kept", 1, 1'b0);

    // Full set with all pairs 00 so the fifth insert lands in way 3
    for (int k = 2; k <= 6; k++) begin
      add_ins($sformatf("ins_s5_%0d", k - 2), k);
    end
    add_hit(OP_LUP, "s5_0_hit", 2, 1'b0);
    add_hit(OP_LUP, "s5_1_hit", 3, 1'b0);
    add_hit(OP_LUP, "s5_2_hit", 4, 1'b0);
    add_miss(OP_LUP, "s5_3_gone", 4'd5, e_tag[5], 6'd2);
    add_hit(OP_LUP, "s5_4_hit", 6, 1'b0);

    // These lookups leave pairs 10 11 10 11 and make way 2 the victim
    for (int k = 7; k <= 10; k++) begin
      add_ins($sformatf("ins_s9_%0d", k - 7), k);
    end
    add_hit(OP_LUP, "s9_0_rd", 7, 1'b0);
    add_hit(OP_LUP, "s9_1_wr", 8, 1'b1);
    add_hit(OP_LUP, "s9_2_rd", 9, 1'b0);
    add_hit(OP_LUP, "s9_3_wr", 10, 1'b1);
    add_ins("ins_s9_new", 11);
    add_miss(OP_LUP, "s9_2_gone", 4'd9, e_tag[9], 6'd3);
    add_hit(OP_LUP, "s9_0_kept", 7, 1'b0);
    add_hit(OP_LUP, "s9_1_kept", 8, 1'b0);
    add_hit(OP_LUP, "s9_3_kept", 10, 1'b0);
    add_hit(OP_LUP, "s9_new_hit", 11, 1'b0);

    // Back-to-back lookups mixing hits and misses
    add_hit(OP_PIPE, "pipe_0_hit", 2, 1'b0);
    add_miss(OP_PIPE, "pipe_1_miss", 4'd5, 16'h0abc, 6'd2);
    add_hit(OP_PIPE, "pipe_2_hit", 8, 1'b0);
    add_miss(OP_PIPE, "pipe_3_miss", 4'd9, e_tag[9], 6'd3);
  endtask

  // ----------------------------------------------------------------------
  // Checks
  // ----------------------------------------------------------------------
  function automatic string format_rsp(input tlb_lup_rsp_t r);
    return $sformatf("valid=%b hit=%b ppn=%h hpid=%h", r.valid, r.hit, r.ppn, r.hpid);
  endfunction

  task automatic check_rsp(input string name, input tlb_lup_rsp_t exp,
                           input tlb_lup_rsp_t act);
    if (act !== exp) begin
      $display("Mismatch %s: expected %s, actual %s", name, format_rsp(exp), format_rsp(act));
      $display("tests failed");
      $fatal(1, "Stopped at the first error");
    end
  endtask

  task automatic check_ready(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      $display("Mismatch %s: expected cmd_ready=%b, actual cmd_ready=%b", name, exp, act);
      $display("tests failed");
      $fatal(1, "Stopped at the first error");
    end
  endtask

  // ----------------------------------------------------------------------
  // Drivers
  // ----------------------------------------------------------------------
  // Advance one cycle and check every response due now
  task automatic step();
    @(posedge aclk);
    #1;
    while (due_q.size() > 0 && due_q[0] == cyc) begin
      check_rsp(name_q.pop_front(), exp_q.pop_front(), lup_rsp);
      void'(due_q.pop_front());
    end
  endtask

  task automatic issue_lookup(input string name, input tlb_lup_req_t q,
                              input tlb_lup_rsp_t e);
    lup_req = q;
    exp_q.push_back(e);
    due_q.push_back(cyc + LUP_LATENCY);
    name_q.push_back(name);
  endtask

  task automatic drain();
    lup_req.valid = 1'b0;
    while (due_q.size() > 0) begin
      step();
    end
  endtask

  // Valid/ready transfer and the wait through the read-modify-write
  task automatic run_cmd(input string name, input tlb_cmd_u c);
    while (!cmd_ready) begin
      step();
    end
    cmd       = c;
    cmd_valid = 1'b1;
    step();
    cmd_valid = 1'b0;
    check_ready(name, 1'b0, cmd_ready);
    while (!cmd_ready) begin
      step();
    end
  endtask

  initial begin
    aresetn   = 1'b0;
    cmd       = '0;
    cmd_valid = 1'b0;
    lup_req   = '0;
    build_table();
    cyc_limit = 12 * row_op.size() + 50;

    repeat (2) @(posedge aclk);
    #1;
    aresetn = 1'b1;
    check_ready("reset_ready", 1'b1, cmd_ready);

    for (int i = 0; i < row_op.size(); i++) begin
      if (row_op[i] != OP_PIPE) begin
        drain();
      end
      if (row_op[i] == OP_CMD) begin
        run_cmd(row_name[i], row_cmd[i]);
      end else begin
        issue_lookup(row_name[i], row_req[i], row_exp[i]);
        step();
      end
    end
    drain();
    // Last responses reach the bound checks one edge later
    repeat (2) step();

    if (u_dut.u_props.fail_cnt != 0) begin
      $display("Bound assertions failed %0d times", u_dut.u_props.fail_cnt);
      $display("tests failed");
      $fatal(1, "Stopped on assertion failures");
    end else begin
      $display("all tests passed");
      $finish;
    end
  end

endmodule

// ==== tlb_top.f ====
tlb_pkg.sv
tlb_ram.sv
tlb_ref_bits.sv
tlb_victim_select.sv
tlb_lookup.sv
tlb_controller.sv
tlb_top.sv
tlb_properties.sv
tb_tlb_top.sv
